// File: design/mmio_map_pkg.sv
package mmio_map_pkg;

    // host bus widths
    typedef logic [31:0] bus_addr_t;
    typedef logic [31:0] bus_data_t;

    // ##################################################################
    // register map of the read path
    // ##################################################################

    // DRAM source byte address
    localparam bus_addr_t RD_ADDR_REG      = 32'hC400_2024;
    // job length in 16-bit words
    localparam bus_addr_t RD_LEN_REG       = 32'hC400_2028;
    // any write starts a job
    localparam bus_addr_t RD_START_REG     = 32'hC400_2030;
    // any write zeroes the scratchpad index
    localparam bus_addr_t SRAM_IDX_CLR_REG = 32'hC400_2034;
    // bit 0 set means weight data
    localparam bus_addr_t DATA_TYPE_REG    = 32'hC400_2038;
    // read only, busy in bit 0
    localparam bus_addr_t BUSY_REG         = 32'hC400_0020;

endpackage

// File: design/feeder_pkg.sv
package feeder_pkg;

    // ##################################################################
    // data widths
    // ##################################################################

    // one operand word for the accelerator
    typedef logic [15:0]  word_t;
    // each half of a DRAM line comes on its own bus
    typedef logic [255:0] half_line_t;
    typedef logic [511:0] line_t;
    typedef logic [31:0]  dram_addr_t;
    // word count and scratchpad index share a width
    typedef logic [14:0]  len_t;
    typedef logic [7:0]   cmd_t;

    localparam int LINE_BYTES     = 64;
    localparam int WORDS_PER_LINE = 32;

    // accelerator write commands
    localparam cmd_t CMD_WRITE_INPUT  = 8'd9;
    localparam cmd_t CMD_WRITE_WEIGHT = 8'd10;

    // ##################################################################
    // state machines
    // ##################################################################

    typedef enum logic [1:0] {
        REQ_IDLE,
        REQ_WAIT_FIFO,
        REQ_SEND
    } req_state_t;

    typedef enum logic [1:0] {
        FEED_IDLE,
        FEED_WAIT_DATA,
        FEED_ISSUE,
        FEED_POP
    } feed_state_t;

endpackage

// File: design/feed_job_if.sv
`timescale 1ns/10ps

interface feed_job_if;
    import feeder_pkg::*;

    // one-cycle pulses from the register stage
    logic       start;
    logic       idx_clr;
    // programmed job
    dram_addr_t base_addr;
    len_t       length;
    logic       weight_sel;
    // stage status back to the busy register
    logic       req_busy;
    logic       feed_busy;

    modport cfg  (output start, idx_clr, base_addr, length, weight_sel,
                  input  req_busy, feed_busy);
    modport req  (input  start, base_addr, length,
                  output req_busy);
    modport feed (input  start, idx_clr, base_addr, length, weight_sel,
                  output feed_busy);
    modport mon  (input  start, idx_clr, base_addr, length, weight_sel,
                  req_busy, feed_busy);

endinterface

// File: design/mmio_regs.sv
`timescale 1ns/10ps

module mmio_regs (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    dev_strobe_i,
    input  mmio_map_pkg::bus_addr_t dev_addr_i,
    input  mmio_map_pkg::bus_data_t dev_wdata_i,
    output logic                    dev_ready_o,
    output mmio_map_pkg::bus_data_t dev_rdata_o,
    feed_job_if.cfg                 job
);
    import mmio_map_pkg::*;
    import feeder_pkg::*;

    logic busy;

    // ##################################################################
    // strobe decode
    // ##################################################################

    // pulses go out in the strobe cycle itself
    assign job.start   = dev_strobe_i && (dev_addr_i == RD_START_REG);
    assign job.idx_clr = dev_strobe_i && (dev_addr_i == SRAM_IDX_CLR_REG);

    // either stage still working
    assign busy = job.req_busy || job.feed_busy;

    always_ff @(posedge clk_i) begin
        if (dev_strobe_i && (dev_addr_i == RD_ADDR_REG)) begin
            job.base_addr <= dram_addr_t'(dev_wdata_i);
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            job.length     <= '0;
            job.weight_sel <= 1'b0;
        end else if (dev_strobe_i) begin
            if (dev_addr_i == RD_LEN_REG) begin
                job.length <= len_t'(dev_wdata_i);
            end
            if (dev_addr_i == DATA_TYPE_REG) begin
                job.weight_sel <= dev_wdata_i[0];
            end
        end
    end

    // ##################################################################
    // bus response
    // ##################################################################

    // every strobe is acknowledged one cycle later
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            dev_ready_o <= 1'b0;
        end else begin
            dev_ready_o <= dev_strobe_i;
        end
    end

    // read data holds until the next busy read
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            dev_rdata_o <= '0;
        end else if (dev_strobe_i && (dev_addr_i == BUSY_REG)) begin
            dev_rdata_o <= bus_data_t'(busy);
        end
    end

    // a new job only starts once both stages are idle
    assert property (@(posedge clk_i) disable iff (rst_i)
        job.start |-> !busy)
        else $error("mmio_regs: job started while a job is still running");

endmodule

// File: design/line_req_gen.sv
`timescale 1ns/10ps

module line_req_gen (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   fifo_addr_full_i,
    output logic                   dram_addr_valid_o,
    output feeder_pkg::dram_addr_t dram_addr_o,
    feed_job_if.req                job
);
    import feeder_pkg::*;

    req_state_t  state_q;
    req_state_t  state_d;
    dram_addr_t  addr_q;
    dram_addr_t  step;
    len_t        req_cnt_q;
    // one bit wider so the count cannot wrap past the length
    logic [15:0] cnt_next;
    logic        last_req;

    // bytes up to the next line boundary, a full line once aligned
    assign step     = dram_addr_t'(LINE_BYTES) - dram_addr_t'(addr_q[5:0]);
    assign cnt_next = {1'b0, req_cnt_q} + 16'(step >> 1);
    assign last_req = cnt_next >= {1'b0, job.length};

    // ##################################################################
    // request FSM
    // ##################################################################

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= REQ_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            REQ_IDLE:      if (job.start) state_d = REQ_WAIT_FIFO;
            REQ_WAIT_FIFO: if (!fifo_addr_full_i) state_d = REQ_SEND;
            REQ_SEND:      state_d = last_req ? REQ_IDLE : REQ_WAIT_FIFO;
            default:       state_d = REQ_IDLE;
        endcase
    end

    // address steps after every request
    always_ff @(posedge clk_i) begin
        if (state_q == REQ_IDLE && job.start) begin
            addr_q <= job.base_addr;
        end else if (state_q == REQ_SEND) begin
            addr_q <= addr_q + step;
        end
    end

    // words covered so far
    always_ff @(posedge clk_i) begin
        if (rst_i || (state_q == REQ_IDLE && job.start)) begin
            req_cnt_q <= '0;
        end else if (state_q == REQ_SEND) begin
            req_cnt_q <= cnt_next[14:0];
        end
    end

    assign dram_addr_valid_o = (state_q == REQ_SEND);
    assign dram_addr_o       = addr_q;
    assign job.req_busy      = (state_q != REQ_IDLE);

    // no request once the covered words reach the length
    assert property (@(posedge clk_i) disable iff (rst_i)
        dram_addr_valid_o |-> (req_cnt_q < job.length))
        else $error("line_req_gen: read request beyond the job length");

endmodule

// File: design/word_feeder.sv
`timescale 1ns/10ps

module word_feeder (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   fifo_data_empty_i,
    input  feeder_pkg::half_line_t dram_rdata_h_i,
    input  feeder_pkg::half_line_t dram_rdata_l_i,
    output logic                   fifo_data_rd_en_o,
    output logic                   acc_cmd_valid_o,
    output feeder_pkg::cmd_t       acc_cmd_o,
    output feeder_pkg::word_t      acc_word_o,
    output feeder_pkg::len_t       acc_index_o,
    feed_job_if.feed               job
);
    import feeder_pkg::*;

    feed_state_t state_q;
    feed_state_t state_d;
    line_t       line_q;
    word_t       words [WORDS_PER_LINE];
    dram_addr_t  word_addr_q;
    len_t        send_cnt_q;
    len_t        sram_idx_q;
    logic        line_done;
    logic        job_done;

    // follows the FIFO head whenever it holds a line
    always_ff @(posedge clk_i) begin
        if (!fifo_data_empty_i) begin
            line_q <= {dram_rdata_h_i, dram_rdata_l_i};
        end
    end

    // word pairs run from the top of each half, even word in the low bits
    always_comb begin
        for (int p = 0; p < WORDS_PER_LINE / 4; p++) begin
            {words[2*p+1], words[2*p]}       = line_q[255-32*p -: 32];
            {words[16+2*p+1], words[16+2*p]} = line_q[511-32*p -: 32];
        end
    end

    // last word of the line or last word of the job
    assign line_done = (word_addr_q[5:1] == 5'd31) ||
                       (len_t'(send_cnt_q + 1'b1) == job.length);
    assign job_done  = (send_cnt_q == job.length);

    // ##################################################################
    // feed FSM
    // ##################################################################

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= FEED_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            FEED_IDLE:      if (job.start) state_d = FEED_WAIT_DATA;
            FEED_WAIT_DATA: if (!fifo_data_empty_i) state_d = FEED_ISSUE;
            FEED_ISSUE:     if (line_done) state_d = FEED_POP;
            FEED_POP:       state_d = job_done ? FEED_IDLE : FEED_WAIT_DATA;
            default:        state_d = FEED_IDLE;
        endcase
    end

    // byte address of the word being sent
    always_ff @(posedge clk_i) begin
        if (state_q == FEED_IDLE && job.start) begin
            word_addr_q <= job.base_addr;
        end else if (state_q == FEED_ISSUE) begin
            word_addr_q <= word_addr_q + dram_addr_t'(2);
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i || (state_q == FEED_IDLE && job.start)) begin
            send_cnt_q <= '0;
        end else if (state_q == FEED_ISSUE) begin
            send_cnt_q <= send_cnt_q + 1'b1;
        end
    end

    // scratchpad index runs on across jobs until cleared
    always_ff @(posedge clk_i) begin
        if (rst_i || job.idx_clr) begin
            sram_idx_q <= '0;
        end else if (state_q == FEED_ISSUE) begin
            sram_idx_q <= sram_idx_q + 1'b1;
        end
    end

    // command registers
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            acc_cmd_valid_o <= 1'b0;
        end else begin
            acc_cmd_valid_o <= (state_q == FEED_ISSUE);
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == FEED_ISSUE) begin
            acc_cmd_o   <= job.weight_sel ? CMD_WRITE_WEIGHT : CMD_WRITE_INPUT;
            acc_word_o  <= words[word_addr_q[5:1]];
            acc_index_o <= sram_idx_q;
        end
    end

    assign fifo_data_rd_en_o = (state_q == FEED_POP);
    assign job.feed_busy     = (state_q != FEED_IDLE);

    assert property (@(posedge clk_i) disable iff (rst_i)
        fifo_data_rd_en_o |-> !fifo_data_empty_i)
        else $error("word_feeder: pop from an empty data FIFO");

endmodule

// File: design/data_feeder_top.sv
`timescale 1ns/10ps

module data_feeder_top (
    input  logic                    clk_i,
    input  logic                    rst_i,

    // host bus
    input  logic                    dev_strobe_i,
    input  mmio_map_pkg::bus_addr_t dev_addr_i,
    input  mmio_map_pkg::bus_data_t dev_wdata_i,
    output logic                    dev_ready_o,
    output mmio_map_pkg::bus_data_t dev_rdata_o,

    // DRAM address FIFO
    input  logic                    fifo_addr_full_i,
    output logic                    dram_addr_valid_o,
    output feeder_pkg::dram_addr_t  dram_addr_o,

    // DRAM data FIFO
    input  logic                    fifo_data_empty_i,
    input  feeder_pkg::half_line_t  dram_rdata_h_i,
    input  feeder_pkg::half_line_t  dram_rdata_l_i,
    output logic                    fifo_data_rd_en_o,

    // accelerator commands
    output logic                    acc_cmd_valid_o,
    output feeder_pkg::cmd_t        acc_cmd_o,
    output feeder_pkg::word_t       acc_word_o,
    output feeder_pkg::len_t        acc_index_o
);

    // job settings shared by all three stages
    feed_job_if job ();

    mmio_regs u_mmio_regs (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .dev_strobe_i (dev_strobe_i),
        .dev_addr_i   (dev_addr_i),
        .dev_wdata_i  (dev_wdata_i),
        .dev_ready_o  (dev_ready_o),
        .dev_rdata_o  (dev_rdata_o),
        .job          (job.cfg)
    );

    line_req_gen u_line_req_gen (
        .clk_i             (clk_i),
        .rst_i             (rst_i),
        .fifo_addr_full_i  (fifo_addr_full_i),
        .dram_addr_valid_o (dram_addr_valid_o),
        .dram_addr_o       (dram_addr_o),
        .job               (job.req)
    );

    word_feeder u_word_feeder (
        .clk_i             (clk_i),
        .rst_i             (rst_i),
        .fifo_data_empty_i (fifo_data_empty_i),
        .dram_rdata_h_i    (dram_rdata_h_i),
        .dram_rdata_l_i    (dram_rdata_l_i),
        .fifo_data_rd_en_o (fifo_data_rd_en_o),
        .acc_cmd_valid_o   (acc_cmd_valid_o),
        .acc_cmd_o         (acc_cmd_o),
        .acc_word_o        (acc_word_o),
        .acc_index_o       (acc_index_o),
        .job               (job.feed)
    );

endmodule

// File: dv/tb_data_feeder.sv
`timescale 1ns/10ps

module tb_data_feeder;
    import mmio_map_pkg::*;
    import feeder_pkg::*;

    localparam int NJOBS      = 6;
    localparam int POLL_LIMIT = 400;

    logic       clk_i;
    logic       rst_i;
    logic       dev_strobe_i;
    bus_addr_t  dev_addr_i;
    bus_data_t  dev_wdata_i;
    logic       dev_ready_o;
    bus_data_t  dev_rdata_o;
    logic       fifo_addr_full_i;
    logic       dram_addr_valid_o;
    dram_addr_t dram_addr_o;
    logic       fifo_data_empty_i;
    half_line_t dram_rdata_h_i;
    half_line_t dram_rdata_l_i;
    logic       fifo_data_rd_en_o;
    logic       acc_cmd_valid_o;
    cmd_t       acc_cmd_o;
    word_t      acc_word_o;
    len_t       acc_index_o;

    // ##################################################################
    // job table
    // ##################################################################

    string      tname   [NJOBS] = '{"aligned_line", "unaligned_multi", "mid_line_short",
                                    "clear_weight", "stall_unaligned", "stall_heavy"};
    dram_addr_t tbase   [NJOBS] = '{32'h0000_1000, 32'h0000_2016, 32'h0000_3024,
                                    32'h0001_0040, 32'h0000_4032, 32'h0002_0000};
    len_t       tlen    [NJOBS] = '{15'd32, 15'd70, 15'd5, 15'd96, 15'd100, 15'd65};
    logic       tweight [NJOBS] = '{1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1};
    logic       tclr    [NJOBS] = '{1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
    // percent of cycles with the address FIFO full
    int         tstall  [NJOBS] = '{0, 0, 0, 0, 50, 80};

    integer     seed = 65556;
    int         stall_pct;
    string      cur_name;
    int         err_cnt;
    int         fail_jobs;
    logic       pop_pend;
    len_t       model_idx;
    // DRAM model holds the request addresses of lines not yet popped
    dram_addr_t line_fifo [$];
    dram_addr_t exp_addr  [$];
    cmd_t       exp_cmd   [$];
    word_t      exp_word  [$];
    len_t       exp_idx   [$];

    data_feeder_top dut (.*);

    initial clk_i = 1'b0;
    always #50 clk_i = ~clk_i;

    task automatic compare_addr(dram_addr_t exp, dram_addr_t act);
        if (act !== exp) begin
            $display("MISMATCH %s request address: expected %h, actual %h", cur_name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic compare_word(word_t exp, word_t act);
        if (act !== exp) begin
            $display("MISMATCH %s word: expected %h, actual %h", cur_name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic compare_cmd(cmd_t exp, cmd_t act);
        if (act !== exp) begin
            $display("MISMATCH %s command: expected %0d, actual %0d", cur_name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic compare_idx(len_t exp, len_t act);
        if (act !== exp) begin
            $display("MISMATCH %s index: expected %0d, actual %0d", cur_name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic compare_bus(bus_data_t exp, bus_data_t act);
        if (act !== exp) begin
            $display("MISMATCH %s busy read: expected %h, actual %h", cur_name, exp, act);
            err_cnt++;
        end
    endtask

    // content of word k in the line at aligned address line_addr
    function automatic word_t line_word(dram_addr_t line_addr, int k);
        return word_t'((line_addr >> 1) + dram_addr_t'(k));
    endfunction

    // word pairs from the top of each half, even word low
    function automatic line_t make_line(dram_addr_t addr);
        dram_addr_t line_addr;
        half_line_t h;
        half_line_t l;
        int         k;
        int         j;
        line_addr = addr & ~dram_addr_t'(LINE_BYTES - 1);
        for (k = 0; k < WORDS_PER_LINE; k++) begin
            j = k % 16;
            if (k < 16) begin
                l[224 - 32 * (j / 2) + 16 * (j % 2) +: 16] = line_word(line_addr, k);
            end else begin
                h[224 - 32 * (j / 2) + 16 * (j % 2) +: 16] = line_word(line_addr, k);
            end
        end
        return {h, l};
    endfunction

    // reference model for one job
    task automatic predict_job(int t);
        dram_addr_t a;
        dram_addr_t step;
        int         covered;
        int         i;
        int         k;
        a = tbase[t];
        covered = 0;
        do begin
            exp_addr.push_back(a);
            step = dram_addr_t'(LINE_BYTES) - (a % LINE_BYTES);
            covered += int'(step / 2);
            a += step;
        end while (covered < int'(tlen[t]));
        a = tbase[t];
        for (i = 0; i < int'(tlen[t]); i++) begin
            // code 10 writes weights, code 9 writes inputs
            exp_cmd.push_back(tweight[t] ? cmd_t'(10) : cmd_t'(9));
            k = int'((a % LINE_BYTES) / 2);
            exp_word.push_back(line_word(a & ~dram_addr_t'(LINE_BYTES - 1), k));
            exp_idx.push_back(model_idx);
            model_idx = model_idx + 1'b1;
            a += 2;
        end
    endtask

    // one strobe, ready expected one cycle later
    task automatic bus_access(bus_addr_t addr, bus_data_t wdata, output bus_data_t rdata);
        @(posedge clk_i);
        #1;
        dev_strobe_i = 1'b1;
        dev_addr_i   = addr;
        dev_wdata_i  = wdata;
        @(posedge clk_i);
        #1;
        dev_strobe_i = 1'b0;
        @(negedge clk_i);
        if (dev_ready_o !== 1'b1) begin
            $display("%s: no ready in the cycle after the strobe to %h", cur_name, addr);
            err_cnt++;
        end
        rdata = dev_rdata_o;
    endtask

    // ##################################################################
    // DRAM model and output monitor
    // ##################################################################

    always @(negedge clk_i) begin
        if (!rst_i) begin
            if (dram_addr_valid_o) begin
                if (exp_addr.size() == 0) begin
                    $display("%s: unexpected read request at %h", cur_name, dram_addr_o);
                    err_cnt++;
                end else begin
                    compare_addr(exp_addr.pop_front(), dram_addr_o);
                end
                line_fifo.push_back(dram_addr_o);
            end
            if (fifo_data_rd_en_o) begin
                pop_pend = 1'b1;
            end
            if (acc_cmd_valid_o) begin
                if (exp_cmd.size() == 0) begin
                    $display("%s: unexpected command with word %h", cur_name, acc_word_o);
                    err_cnt++;
                end else begin
                    compare_cmd(exp_cmd.pop_front(), acc_cmd_o);
                    compare_word(exp_word.pop_front(), acc_word_o);
                    compare_idx(exp_idx.pop_front(), acc_index_o);
                end
            end
        end
    end

    always @(posedge clk_i) begin
        #1;
        if (pop_pend && line_fifo.size() > 0) begin
            line_fifo.delete(0);
        end
        pop_pend = 1'b0;
        fifo_addr_full_i = (stall_pct > 0) && (($unsigned($random(seed)) % 100) < stall_pct);
        if (line_fifo.size() > 0) begin
            fifo_data_empty_i = 1'b0;
            {dram_rdata_h_i, dram_rdata_l_i} = make_line(line_fifo[0]);
        end else begin
            fifo_data_empty_i = 1'b1;
        end
    end

    // ##################################################################
    // job sequence
    // ##################################################################

    initial begin
        bus_data_t rd;
        int        polls;
        int        errs_before;
        int        t;
        rst_i             = 1'b1;
        dev_strobe_i      = 1'b0;
        dev_addr_i        = '0;
        dev_wdata_i       = '0;
        fifo_addr_full_i  = 1'b0;
        fifo_data_empty_i = 1'b1;
        dram_rdata_h_i    = '0;
        dram_rdata_l_i    = '0;
        err_cnt           = 0;
        fail_jobs         = 0;
        pop_pend          = 1'b0;
        stall_pct         = 0;
        model_idx         = '0;
        cur_name          = "reset";
        repeat (2) @(posedge clk_i);
        #1;
        rst_i = 1'b0;

        for (t = 0; t < NJOBS; t++) begin
            cur_name = tname[t];
            errs_before = err_cnt;
            if (tclr[t]) begin
                bus_access(SRAM_IDX_CLR_REG, '0, rd);
                model_idx = '0;
            end
            bus_access(RD_ADDR_REG, bus_data_t'(tbase[t]), rd);
            bus_access(RD_LEN_REG, bus_data_t'(tlen[t]), rd);
            bus_access(DATA_TYPE_REG, bus_data_t'(tweight[t]), rd);
            predict_job(t);
            stall_pct = tstall[t];
            bus_access(RD_START_REG, '0, rd);
            bus_access(BUSY_REG, '0, rd);
            compare_bus(32'd1, rd);
            // poll until busy drops
            polls = 0;
            while (rd != 0 && polls < POLL_LIMIT) begin
                bus_access(BUSY_REG, '0, rd);
                polls++;
            end
            stall_pct = 0;
            if (rd != 0) begin
                $display("%s: timeout, job still busy after %0d busy reads", cur_name, polls);
                err_cnt++;
            end
            if (exp_addr.size() != 0 || exp_cmd.size() != 0) begin
                $display("%s: %0d requests and %0d commands missing when busy fell",
                         cur_name, exp_addr.size(), exp_cmd.size());
                err_cnt++;
            end
            if (line_fifo.size() != 0) begin
                $display("%s: %0d lines left in the data FIFO", cur_name, line_fifo.size());
                err_cnt++;
            end
            exp_addr.delete();
            exp_cmd.delete();
            exp_word.delete();
            exp_idx.delete();
            if (err_cnt != errs_before) begin
                fail_jobs++;
            end
            $display("job %-16s %s", cur_name, (err_cnt == errs_before) ? "ok" : "failed");
        end

        $display("jobs %0d, failed %0d, errors %0d", NJOBS, fail_jobs, err_cnt);
        if (err_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: tb.f
design/mmio_map_pkg.sv
design/feeder_pkg.sv
design/feed_job_if.sv
design/mmio_regs.sv
design/line_req_gen.sv
design/word_feeder.sv
design/data_feeder_top.sv
dv/tb_data_feeder.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_data_feeder
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "TB PASSED" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
